// ==== Bender.yml ====
package:
  name: motion_top

sources:
  - files:
      - design/motion_pkg.sv
      - design/regmap_pkg.sv
      - design/control_regs.sv
      - design/tick_timer.sv
      - design/profile_gen.sv
      - design/step_pulse.sv
      - design/motor_router.sv
      - design/endstop_guard.sv
      - design/motion_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_motion_top.sv

// ==== design/control_regs.sv ====
`timescale 1ns/1ps

module control_regs
    import motion_pkg::*;
    import regmap_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    reg_wr,
    input  reg_addr_t               reg_waddr,
    input  word_t                   reg_wdata,
    input  reg_addr_t               reg_raddr,
    output word_t                   reg_rdata,
    input  logic                    busy,
    input  logic                    done,
    input  word_t                   tick_count,
    input  logic                    aborted,
    input  logic [NUM_ENDSTOPS-1:0] endstop_level,
    input  word_t                   axis_pos_hi [NUM_AXES],
    input  vel_t                    axis_vel [NUM_AXES],
    output logic                    load,
    output logic                    unlock,
    output word_t                   dt,
    output word_t                   ticks,
    output word_t                   pre,
    output word_t                   pulse,
    output word_t                   post,
    output word_t                   route,
    output word_t                   endstop_cfg,
    output pos_t                    axis_x [NUM_AXES],
    output vel_t                    axis_v [NUM_AXES],
    output acc_t                    axis_a [NUM_AXES]
);

    word_t cfg [REG_DT:CFG_WORDS-1];
    logic  done_flag;  // Sticky until next load
    word_t status;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = REG_DT; i < CFG_WORDS; i++) begin
                cfg[i] <= '0;
            end
            load      <= 1'b0;
            unlock    <= 1'b0;
            done_flag <= 1'b0;
        end else begin
            load   <= reg_wr && reg_waddr == REG_CTRL && reg_wdata[CTRL_LOAD];
            unlock <= reg_wr && reg_waddr == REG_CTRL && reg_wdata[CTRL_UNLOCK];
            if (reg_wr && reg_waddr >= REG_DT && reg_waddr < CFG_WORDS) begin
                cfg[reg_waddr] <= reg_wdata;
            end
            if (load) begin
                done_flag <= 1'b0;
            end else if (done) begin
                done_flag <= 1'b1;
            end
        end
    end

    always_comb begin
        status = '0;
        status[STAT_BUSY]    = busy;
        status[STAT_DONE]    = done_flag;
        status[STAT_ABORTED] = aborted;
        status[STAT_ES_LSB +: NUM_ENDSTOPS] = endstop_level;
    end

    always_comb begin
        reg_rdata = '0;  // CTRL and holes read zero
        if (reg_raddr >= REG_DT && reg_raddr < CFG_WORDS) begin
            reg_rdata = cfg[reg_raddr];
        end
        if (reg_raddr == REG_STATUS) begin
            reg_rdata = status;
        end
        if (reg_raddr == REG_TICK_COUNT) begin
            reg_rdata = tick_count;
        end
        for (int i = 0; i < NUM_AXES; i++) begin
            if (reg_raddr == REG_POS_BASE + i * POS_STRIDE) begin
                reg_rdata = axis_pos_hi[i];
            end
            if (reg_raddr == REG_POS_BASE + i * POS_STRIDE + 1) begin
                reg_rdata = axis_vel[i];
            end
        end
    end

    assign dt          = cfg[REG_DT];
    assign ticks       = cfg[REG_TICKS];
    assign pre         = cfg[REG_PRE];
    assign pulse       = cfg[REG_PULSE];
    assign post        = cfg[REG_POST];
    assign route       = cfg[REG_ROUTE];
    assign endstop_cfg = cfg[REG_ENDSTOP];

    always_comb begin
        for (int i = 0; i < NUM_AXES; i++) begin
            axis_x[i] = {cfg[REG_AXIS_BASE + i * AXIS_STRIDE + AXIS_X_HI],
                         cfg[REG_AXIS_BASE + i * AXIS_STRIDE + AXIS_X_LO]};
            axis_v[i] = cfg[REG_AXIS_BASE + i * AXIS_STRIDE + AXIS_V];
            axis_a[i] = cfg[REG_AXIS_BASE + i * AXIS_STRIDE + AXIS_A];
        end
    end

endmodule

// ==== design/endstop_guard.sv ====
`timescale 1ns/1ps

module endstop_guard
    import motion_pkg::*;
    import regmap_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [NUM_ENDSTOPS-1:0] endstop,
    input  word_t                   endstop_cfg,
    input  logic                    busy,
    input  logic                    unlock,
    output logic [NUM_ENDSTOPS-1:0] endstop_level,
    output logic                    abort,
    output logic                    aborted
);

    logic [NUM_ENDSTOPS-1:0] meta;
    logic [NUM_ENDSTOPS-1:0] hit;

    for (genvar i = 0; i < NUM_ENDSTOPS; i++) begin : g_es
        assign hit[i] = endstop_cfg[i * ES_FIELD + ES_EN]
                     && endstop_level[i] == endstop_cfg[i * ES_FIELD + ES_POL];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            meta          <= '0;
            endstop_level <= '0;
            abort         <= 1'b0;
            aborted       <= 1'b0;
        end else begin
            meta          <= endstop;
            endstop_level <= meta;
            abort         <= busy && |hit && !abort;  // Single pulse per run
            if (abort) begin
                aborted <= 1'b1;
            end else if (unlock) begin
                aborted <= 1'b0;
            end
        end
    end

    // Timer must drop busy right after an abort
    a_abort_stops: assert property (@(posedge clk) disable iff (!arst_n)
        abort |=> !busy);

endmodule

// ==== design/motion_pkg.sv ====
package motion_pkg;

    localparam int NUM_AXES     = 3;
    localparam int NUM_MOTORS   = 6;
    localparam int NUM_ENDSTOPS = 3;

    // Lowest integer bit of the position
    localparam int STEP_BIT = 32;

    typedef logic [31:0] word_t;

    // 32.32 fixed point
    typedef logic signed [63:0] pos_t;

    typedef logic signed [31:0] vel_t;
    typedef logic signed [31:0] acc_t;

    typedef logic [1:0] axis_sel_t;

    typedef enum logic [1:0] {
        IDLE,
        PRE,
        PULSE,
        POST
    } pulse_state_t;

endpackage

// ==== design/motion_top.sv ====
`timescale 1ns/1ps

module motion_top
    import motion_pkg::*;
    import regmap_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    reg_wr,
    input  reg_addr_t               reg_waddr,
    input  word_t                   reg_wdata,
    input  reg_addr_t               reg_raddr,
    output word_t                   reg_rdata,
    input  logic [NUM_ENDSTOPS-1:0] endstop,
    output logic [NUM_MOTORS-1:0]   mot_step,
    output logic [NUM_MOTORS-1:0]   mot_dir,
    output logic [NUM_MOTORS-1:0]   mot_enable_n
);

    logic  load;
    logic  unlock;
    logic  tick;
    logic  busy;
    logic  done;
    logic  abort;
    logic  aborted;
    word_t tick_count;
    word_t dt;
    word_t ticks;
    word_t pre;
    word_t pulse;
    word_t post;
    word_t route;
    word_t endstop_cfg;

    logic [NUM_ENDSTOPS-1:0] endstop_level;

    pos_t  axis_x [NUM_AXES];
    vel_t  axis_v [NUM_AXES];
    acc_t  axis_a [NUM_AXES];
    pos_t  axis_pos [NUM_AXES];
    vel_t  axis_vel [NUM_AXES];
    word_t axis_pos_hi [NUM_AXES];

    logic [NUM_AXES-1:0] step_stb;
    logic [NUM_AXES-1:0] step_dir;
    logic [NUM_AXES-1:0] axis_step;
    logic [NUM_AXES-1:0] axis_dir;

    control_regs u_regs (
        .clk(clk), .arst_n(arst_n),
        .reg_wr(reg_wr), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .reg_raddr(reg_raddr), .reg_rdata(reg_rdata),
        .busy(busy), .done(done), .tick_count(tick_count),
        .aborted(aborted), .endstop_level(endstop_level),
        .axis_pos_hi(axis_pos_hi), .axis_vel(axis_vel),
        .load(load), .unlock(unlock),
        .dt(dt), .ticks(ticks), .pre(pre), .pulse(pulse), .post(post),
        .route(route), .endstop_cfg(endstop_cfg),
        .axis_x(axis_x), .axis_v(axis_v), .axis_a(axis_a)
    );

    tick_timer u_timer (
        .clk(clk), .arst_n(arst_n),
        .load(load), .abort(abort), .dt(dt), .ticks(ticks),
        .tick(tick), .busy(busy), .done(done), .tick_count(tick_count)
    );

    endstop_guard u_guard (
        .clk(clk), .arst_n(arst_n),
        .endstop(endstop), .endstop_cfg(endstop_cfg),
        .busy(busy), .unlock(unlock),
        .endstop_level(endstop_level), .abort(abort), .aborted(aborted)
    );

    for (genvar i = 0; i < NUM_AXES; i++) begin : g_axis
        profile_gen u_profile (
            .clk(clk), .arst_n(arst_n), .load(load), .tick(tick),
            .x_init(axis_x[i]), .v_init(axis_v[i]), .a_init(axis_a[i]),
            .x(axis_pos[i]), .v(axis_vel[i]),
            .step_stb(step_stb[i]), .step_dir(step_dir[i])
        );

        step_pulse u_pulse (
            .clk(clk), .arst_n(arst_n),
            .step_stb(step_stb[i]), .step_dir(step_dir[i]),
            .pre(pre), .pulse(pulse), .post(post),
            .step(axis_step[i]), .dir(axis_dir[i])
        );

        assign axis_pos_hi[i] = axis_pos[i][STEP_BIT +: $bits(word_t)];
    end

    motor_router u_router (
        .clk(clk), .arst_n(arst_n),
        .axis_step(axis_step), .axis_dir(axis_dir), .route(route),
        .mot_step(mot_step), .mot_dir(mot_dir), .mot_enable_n(mot_enable_n)
    );

endmodule

// ==== design/motor_router.sv ====
`timescale 1ns/1ps

module motor_router
    import motion_pkg::*;
    import regmap_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [NUM_AXES-1:0]   axis_step,
    input  logic [NUM_AXES-1:0]   axis_dir,
    input  word_t                 route,
    output logic [NUM_MOTORS-1:0] mot_step,
    output logic [NUM_MOTORS-1:0] mot_dir,
    output logic [NUM_MOTORS-1:0] mot_enable_n
);

    logic [NUM_MOTORS-1:0] step_d;
    logic [NUM_MOTORS-1:0] dir_d;
    logic [NUM_MOTORS-1:0] en;

    for (genvar m = 0; m < NUM_MOTORS; m++) begin : g_motor
        axis_sel_t sel;
        logic      valid;

        assign sel   = route[m * ROUTE_FIELD + ROUTE_SEL_LSB +: $bits(axis_sel_t)];
        assign valid = sel < NUM_AXES;  // Select 3 is quiet
        assign en[m] = route[m * ROUTE_FIELD + ROUTE_EN];

        assign step_d[m] = valid ? axis_step[sel] : 1'b0;
        assign dir_d[m]  = valid ? axis_dir[sel] ^ route[m * ROUTE_FIELD + ROUTE_INV] : 1'b0;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mot_step     <= '0;
            mot_dir      <= '0;
            mot_enable_n <= '1;  // Drivers off
        end else begin
            mot_step     <= step_d;
            mot_dir      <= dir_d;
            mot_enable_n <= ~en;
        end
    end

endmodule

// ==== design/profile_gen.sv ====
`timescale 1ns/1ps

module profile_gen
    import motion_pkg::*;
(
    input  logic clk,
    input  logic arst_n,
    input  logic load,
    input  logic tick,
    input  pos_t x_init,
    input  vel_t v_init,
    input  acc_t a_init,
    output pos_t x,
    output vel_t v,
    output logic step_stb,
    output logic step_dir
);

    acc_t a;
    pos_t x_next;

    assign x_next = x + pos_t'(v);  // Old v sign extended

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            x        <= '0;
            v        <= '0;
            a        <= '0;
            step_stb <= 1'b0;
            step_dir <= 1'b0;
        end else begin
            step_stb <= 1'b0;
            if (load) begin
                x <= x_init;
                v <= v_init;
                a <= a_init;
            end else if (tick) begin
                x        <= x_next;
                v        <= v + a;
                step_stb <= x_next[STEP_BIT] != x[STEP_BIT];
                step_dir <= !v[$bits(vel_t)-1];  // Non-negative increment
            end
        end
    end

endmodule

// ==== design/regmap_pkg.sv ====
package regmap_pkg;

    typedef logic [5:0] reg_addr_t;

    localparam reg_addr_t REG_CTRL      = 6'd0;
    localparam reg_addr_t REG_DT        = 6'd1;
    localparam reg_addr_t REG_TICKS     = 6'd2;
    localparam reg_addr_t REG_PRE       = 6'd3;
    localparam reg_addr_t REG_PULSE     = 6'd4;
    localparam reg_addr_t REG_POST      = 6'd5;
    localparam reg_addr_t REG_ROUTE     = 6'd6;
    localparam reg_addr_t REG_ENDSTOP   = 6'd7;
    localparam reg_addr_t REG_AXIS_BASE = 6'd8;
    localparam int        AXIS_STRIDE   = 4;
    localparam int        CFG_WORDS     = 20;  // One past the last axis word

    // Read-only words
    localparam reg_addr_t REG_STATUS     = 6'd32;
    localparam reg_addr_t REG_TICK_COUNT = 6'd33;
    localparam reg_addr_t REG_POS_BASE   = 6'd34;
    localparam int        POS_STRIDE     = 2;

    // Offsets inside one axis block
    localparam int AXIS_X_LO = 0;
    localparam int AXIS_X_HI = 1;
    localparam int AXIS_V    = 2;
    localparam int AXIS_A    = 3;

    localparam int CTRL_LOAD   = 0;
    localparam int CTRL_UNLOCK = 1;

    localparam int STAT_BUSY    = 0;
    localparam int STAT_DONE    = 1;
    localparam int STAT_ABORTED = 2;
    localparam int STAT_ES_LSB  = 8;

    // Per motor enable, axis select and invert bits
    localparam int ROUTE_FIELD   = 4;
    localparam int ROUTE_EN      = 0;
    localparam int ROUTE_SEL_LSB = 1;
    localparam int ROUTE_INV     = 3;

    // Per endstop polarity and abort enable bits
    localparam int ES_FIELD = 2;
    localparam int ES_POL   = 0;
    localparam int ES_EN    = 1;

endpackage

// ==== design/step_pulse.sv ====
`timescale 1ns/1ps

module step_pulse
    import motion_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  step_stb,
    input  logic  step_dir,
    input  word_t pre,
    input  word_t pulse,
    input  word_t post,
    output logic  step,
    output logic  dir
);

    pulse_state_t state;
    word_t        cnt;
    logic         last;

    // A zero length still spends one cycle in its state
    assign last = cnt <= 1;
    assign step = state == PULSE;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            cnt   <= '0;
            dir   <= 1'b0;
        end else begin
            cnt <= cnt - 1'b1;
            case (state)
                IDLE: begin
                    if (step_stb) begin
                        state <= PRE;
                        cnt   <= pre;
                        dir   <= step_dir;
                    end
                end
                PRE: begin
                    if (last) begin
                        state <= PULSE;
                        cnt   <= pulse;
                    end
                end
                PULSE: begin
                    if (last) begin
                        state <= POST;
                        cnt   <= post;
                    end
                end
                default: begin
                    if (last) state <= IDLE;
                end
            endcase
        end
    end

    // Steps must be spaced wider than the whole pulse
    a_stb_idle: assert property (@(posedge clk) disable iff (!arst_n)
        step_stb |-> state == IDLE);

endmodule

// ==== design/tick_timer.sv ====
`timescale 1ns/1ps

module tick_timer
    import motion_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  load,
    input  logic  abort,
    input  word_t dt,
    input  word_t ticks,
    output logic  tick,
    output logic  busy,
    output logic  done,
    output word_t tick_count
);

    word_t cnt;  // Cycles to next tick

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt        <= '0;
            tick       <= 1'b0;
            busy       <= 1'b0;
            done       <= 1'b0;
            tick_count <= '0;
        end else begin
            tick <= 1'b0;
            done <= 1'b0;
            if (tick) begin
                tick_count <= tick_count + 1'b1;
            end
            if (load) begin
                busy       <= 1'b1;
                cnt        <= dt - 1'b1;  // Load cycle counts as the first
                tick_count <= '0;
            end else if (abort) begin
                busy <= 1'b0;
            end else if (busy) begin
                if (tick && tick_count + 1'b1 == ticks) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else if (cnt == 1) begin
                    tick <= 1'b1;
                    cnt  <= dt;
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end
        end
    end

    a_dt_min: assert property (@(posedge clk) disable iff (!arst_n)
        load |-> dt >= 2);

endmodule

// ==== motion_top.f ====
+incdir+include
design/motion_pkg.sv
design/regmap_pkg.sv
design/control_regs.sv
design/tick_timer.sv
design/profile_gen.sv
design/step_pulse.sv
design/motor_router.sv
design/endstop_guard.sv
design/motion_top.sv
tests/tb_motion_top.sv

// ==== include/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int unsigned err_word = 0;
int unsigned err_pos  = 0;
int unsigned err_bits = 0;
int unsigned err_done = 0;

task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
        err_word++;
        $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
endtask

task automatic check_pos(input string name, input pos_t got, input pos_t exp);
    if (got !== exp) begin
        err_pos++;
        $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
endtask

task automatic check_bits(input string name, input logic [NUM_MOTORS-1:0] got,
                          input logic [NUM_MOTORS-1:0] exp);
    if (got !== exp) begin
        err_bits++;
        $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
endtask

task automatic report_missing_done(input string what);
    err_done++;
    $display("The %s run never reported done before the time limit", what);
endtask

function automatic int unsigned error_total();
    return err_word + err_pos + err_bits + err_done;
endfunction

task automatic report_summary();
    $display("Errors: word %0d, pos %0d, bits %0d, done %0d",
             err_word, err_pos, err_bits, err_done);
endtask

`endif

// ==== tests/tb_motion_top.sv ====
`timescale 1ns/1ps

module tb_motion_top
    import motion_pkg::*;
    import regmap_pkg::*;
();

    localparam int NUM_RUNS  = 6;
    localparam int ABORT_RUN = 4;  // Runs before it complete normally
    localparam int DRAIN     = 40; // Cycles for the last step pulse to leave the router

    logic                    clk;
    logic                    arst_n;
    logic                    reg_wr;
    reg_addr_t               reg_waddr;
    word_t                   reg_wdata;
    reg_addr_t               reg_raddr;
    word_t                   reg_rdata;
    logic [NUM_ENDSTOPS-1:0] endstop;
    logic [NUM_MOTORS-1:0]   mot_step;
    logic [NUM_MOTORS-1:0]   mot_dir;
    logic [NUM_MOTORS-1:0]   mot_enable_n;

    word_t run_dt [NUM_RUNS];
    word_t run_ticks [NUM_RUNS];
    bit    runs_ready;
    word_t cur_route;

    // Model state per axis
    pos_t        init_x [NUM_AXES];
    vel_t        init_v [NUM_AXES];
    acc_t        init_a [NUM_AXES];
    pos_t        exp_x [NUM_AXES];
    vel_t        exp_v [NUM_AXES];
    int unsigned exp_fwd [NUM_AXES];
    int unsigned exp_rev [NUM_AXES];

    // Pulses seen on each motor by direction
    int unsigned           seen_fwd [NUM_MOTORS];
    int unsigned           seen_rev [NUM_MOTORS];
    logic [NUM_MOTORS-1:0] step_prev;

    `include "tb_checks.svh"

    motion_top UUT (
        .clk(clk), .arst_n(arst_n),
        .reg_wr(reg_wr), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .reg_raddr(reg_raddr), .reg_rdata(reg_rdata),
        .endstop(endstop),
        .mot_step(mot_step), .mot_dir(mot_dir), .mot_enable_n(mot_enable_n)
    );

    always #10 clk = ~clk;

    always @(negedge clk) begin
        for (int m = 0; m < NUM_MOTORS; m++) begin
            if (mot_step[m] && !step_prev[m]) begin
                if (mot_dir[m]) begin
                    seen_fwd[m]++;
                end else begin
                    seen_rev[m]++;
                end
            end
        end
        step_prev = mot_step;
    end

    task automatic clear_counts();
        for (int m = 0; m < NUM_MOTORS; m++) begin
            seen_fwd[m] = 0;
            seen_rev[m] = 0;
        end
        step_prev = '0;
    endtask

    task automatic write_reg(input reg_addr_t addr, input word_t data);
        @(negedge clk);
        reg_wr    = 1'b1;
        reg_waddr = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_wr = 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t addr, output word_t data);
        @(negedge clk);
        reg_raddr = addr;
        #1;
        data = reg_rdata;
    endtask

    task automatic wait_status(input int bit_idx, input bit level, input int unsigned limit,
                               output bit hit);
        word_t st;
        hit = 1'b0;
        for (int unsigned c = 0; c < limit && !hit; c++) begin
            read_reg(REG_STATUS, st);
            hit = st[bit_idx] == level;
        end
    endtask

    task automatic close_test();
        report_summary();
        if (error_total() == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    // Once per tick x gains the old v and v gains a
    task automatic model_run(input word_t nt);
        pos_t xn;
        for (int i = 0; i < NUM_AXES; i++) begin
            exp_x[i]   = init_x[i];
            exp_v[i]   = init_v[i];
            exp_fwd[i] = 0;
            exp_rev[i] = 0;
            for (int unsigned t = 0; t < nt; t++) begin
                xn = exp_x[i] + {{32{exp_v[i][31]}}, exp_v[i]};
                if (xn[STEP_BIT] != exp_x[i][STEP_BIT]) begin
                    if (exp_v[i] >= 0) begin
                        exp_fwd[i]++;
                    end else begin
                        exp_rev[i]++;
                    end
                end
                exp_x[i] = xn;
                exp_v[i] = exp_v[i] + init_a[i];
            end
        end
    endtask

    task automatic program_run(input int r, input word_t es_cfg);
        int base;
        write_reg(REG_DT, run_dt[r]);
        write_reg(REG_TICKS, run_ticks[r]);
        write_reg(REG_PRE, $urandom_range(4, 1));
        write_reg(REG_PULSE, $urandom_range(4, 1));
        write_reg(REG_POST, $urandom_range(4, 1));
        cur_route = $urandom & 32'h00ff_ffff;
        write_reg(REG_ROUTE, cur_route);
        write_reg(REG_ENDSTOP, es_cfg);
        for (int i = 0; i < NUM_AXES; i++) begin
            init_x[i] = {$urandom, $urandom};
            init_v[i] = vel_t'($urandom_range(32'h7fff_ffff, 0) - 32'h4000_0000);
            init_a[i] = acc_t'($urandom_range(32'h00ff_ffff, 0) - 32'h0080_0000);
            base      = REG_AXIS_BASE + i * AXIS_STRIDE;
            write_reg(reg_addr_t'(base + AXIS_X_LO), init_x[i][31:0]);
            write_reg(reg_addr_t'(base + AXIS_X_HI), init_x[i][63:32]);
            write_reg(reg_addr_t'(base + AXIS_V), init_v[i]);
            write_reg(reg_addr_t'(base + AXIS_A), init_a[i]);
        end
    endtask

    task automatic start_run();
        clear_counts();
        write_reg(REG_CTRL, word_t'(1) << CTRL_LOAD);
    endtask

    task automatic check_run(input int r);
        word_t                 val;
        word_t                 exp_status;
        word_t                 exp_f;
        word_t                 exp_r;
        bit                    hit;
        axis_sel_t             sel;
        int                    fb;
        logic [NUM_MOTORS-1:0] exp_en_n;
        wait_status(STAT_DONE, 1'b1, run_dt[r] * run_ticks[r] + 200, hit);
        if (!hit) begin
            report_missing_done("programmed");
        end
        model_run(run_ticks[r]);
        exp_status = (word_t'(1) << STAT_DONE) | (word_t'(endstop) << STAT_ES_LSB);
        read_reg(REG_STATUS, val);
        check_word("status after done", val, exp_status);
        read_reg(REG_TICK_COUNT, val);
        check_word("tick_count", val, run_ticks[r]);
        for (int i = 0; i < NUM_AXES; i++) begin
            read_reg(reg_addr_t'(REG_POS_BASE + i * POS_STRIDE), val);
            check_word($sformatf("axis %0d pos_hi", i), val, exp_x[i][63:32]);
            read_reg(reg_addr_t'(REG_POS_BASE + i * POS_STRIDE + 1), val);
            check_word($sformatf("axis %0d vel", i), val, exp_v[i]);
        end
        repeat (DRAIN) @(negedge clk);
        for (int m = 0; m < NUM_MOTORS; m++) begin
            fb          = m * ROUTE_FIELD;
            sel         = cur_route[fb + ROUTE_SEL_LSB +: $bits(axis_sel_t)];
            exp_en_n[m] = !cur_route[fb + ROUTE_EN];
            exp_f       = 0;
            exp_r       = 0;
            if (sel < NUM_AXES) begin
                exp_f = cur_route[fb + ROUTE_INV] ? exp_rev[sel] : exp_fwd[sel];
                exp_r = cur_route[fb + ROUTE_INV] ? exp_fwd[sel] : exp_rev[sel];
            end
            check_word($sformatf("mot_step[%0d] dir high count", m), seen_fwd[m], exp_f);
            check_word($sformatf("mot_step[%0d] dir low count", m), seen_rev[m], exp_r);
        end
        check_bits("mot_enable_n", mot_enable_n, exp_en_n);
        check_bits("mot_step after drain", mot_step, '0);
    endtask

    initial begin
        longint unsigned limit;
        wait (runs_ready);
        limit = 400;  // Reset and register tests
        for (int r = 0; r < NUM_RUNS; r++) begin
            limit += run_dt[r] * run_ticks[r] + 200;
        end
        limit *= 2;
        repeat (limit) @(posedge clk);
        report_missing_done("overall");
        close_test();
    end

    initial begin
        word_t wr_vals [CFG_WORDS];
        word_t val;
        word_t stop_count;
        word_t es_cfg;
        pos_t  pos_val;
        bit    hit;
        int    base;
        clk        = 1'b0;
        arst_n     = 1'b0;
        reg_wr     = 1'b0;
        reg_waddr  = '0;
        reg_wdata  = '0;
        reg_raddr  = '0;
        endstop    = '0;
        cur_route  = '0;
        runs_ready = 1'b0;
        void'($urandom(32));
        for (int r = 0; r < NUM_RUNS; r++) begin
            run_dt[r]    = 17 + $urandom_range(20, 0);  // Above the worst pulse budget
            run_ticks[r] = $urandom_range(40, 5);
        end
        run_ticks[ABORT_RUN] = $urandom_range(40, 20);
        runs_ready = 1'b1;
        clear_counts();
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        for (int addr = 0; addr < 64; addr++) begin
            read_reg(reg_addr_t'(addr), val);
            check_word($sformatf("reset read 0x%02h", addr), val, '0);
        end
        check_bits("mot_step at reset", mot_step, '0);
        check_bits("mot_dir at reset", mot_dir, '0);
        check_bits("mot_enable_n at reset", mot_enable_n, '1);

        for (int addr = REG_DT; addr < CFG_WORDS; addr++) begin
            wr_vals[addr] = $urandom;
            write_reg(reg_addr_t'(addr), wr_vals[addr]);
        end
        for (int addr = REG_DT; addr < REG_AXIS_BASE; addr++) begin
            read_reg(reg_addr_t'(addr), val);
            check_word($sformatf("readback 0x%02h", addr), val, wr_vals[addr]);
        end
        for (int i = 0; i < NUM_AXES; i++) begin
            base = REG_AXIS_BASE + i * AXIS_STRIDE;
            read_reg(reg_addr_t'(base + AXIS_X_LO), val);
            pos_val[31:0] = val;
            read_reg(reg_addr_t'(base + AXIS_X_HI), val);
            pos_val[63:32] = val;
            check_pos($sformatf("axis %0d x readback", i), pos_val,
                      {wr_vals[base + AXIS_X_HI], wr_vals[base + AXIS_X_LO]});
            read_reg(reg_addr_t'(base + AXIS_V), val);
            check_word($sformatf("axis %0d v readback", i), val, wr_vals[base + AXIS_V]);
            read_reg(reg_addr_t'(base + AXIS_A), val);
            check_word($sformatf("axis %0d a readback", i), val, wr_vals[base + AXIS_A]);
        end

        for (int r = 0; r < ABORT_RUN; r++) begin
            program_run(r, '0);
            start_run();
            check_run(r);
        end

        // Endstop 0 aborts when high while endstops 1 and 2 sit active but disabled
        es_cfg = 32'b00_01_11;
        program_run(ABORT_RUN, es_cfg);
        start_run();
        val = '0;
        for (int c = 0; c < 3 * run_dt[ABORT_RUN] + 200 && val < 2; c++) begin
            read_reg(REG_TICK_COUNT, val);
        end
        if (val < 2) begin
            err_done++;
            $display("The abort run never reached its second tick");
        end
        @(negedge clk);
        endstop = 3'b010;
        repeat (5) @(negedge clk);
        read_reg(REG_STATUS, val);
        check_word("status with disabled endstop", val,
                   (word_t'(1) << STAT_BUSY) | (word_t'(3'b010) << STAT_ES_LSB));
        @(negedge clk);
        endstop = 3'b011;
        wait_status(STAT_BUSY, 1'b0, 20, hit);
        if (!hit) begin
            err_word++;
            $display("Endstop 0 did not stop the run");
        end
        read_reg(REG_STATUS, val);
        check_word("status after abort", val,
                   (word_t'(1) << STAT_ABORTED) | (word_t'(3'b011) << STAT_ES_LSB));
        read_reg(REG_TICK_COUNT, stop_count);
        repeat (2 * run_dt[ABORT_RUN]) @(negedge clk);
        read_reg(REG_TICK_COUNT, val);
        if (val != stop_count) begin
            err_word++;
            $display("Tick count moved from %0d to %0d after the abort", stop_count, val);
        end
        if (val >= run_ticks[ABORT_RUN]) begin
            err_word++;
            $display("Tick count %0d did not stop below %0d after the abort",
                     val, run_ticks[ABORT_RUN]);
        end

        @(negedge clk);
        endstop = 3'b010;
        write_reg(REG_CTRL, word_t'(1) << CTRL_UNLOCK);
        repeat (4) @(negedge clk);
        read_reg(REG_STATUS, val);
        check_word("status after unlock", val, word_t'(3'b010) << STAT_ES_LSB);
        program_run(ABORT_RUN + 1, es_cfg);
        start_run();
        check_run(ABORT_RUN + 1);

        close_test();
    end

endmodule
